// File: build.f
+incdir+verilog
verilog/csr_pkg.sv
verilog/pmu_pkg.sv
verilog/csr_decode_stage.sv
verilog/csr_access_stage.sv
verilog/hpm_counters.sv
verilog/top_perfmon.sv
sim/tb_top_perfmon.sv

// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_top_perfmon \
        -f build.f -o sim_tb; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_tb 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Simulation passed" <<< "$sim_out"; then
    exit 0
fi

echo "pass line not found in simulation output"
exit 1

// File: sim/tb_top_perfmon.sv
`include "perf_consts.svh"

module tb_top_perfmon;
    import csr_pkg::*;
    import pmu_pkg::*;

    localparam int NCNT        = `PERF_NUM_COUNTERS;
    localparam int MAX_XFER    = 300;                    // transfers over all tests, rounded up
    localparam int CYCLE_LIMIT = MAX_XFER * 6 + 200;     // 6 cycles each plus reset and idle

    logic                        clk_i;
    logic                        rstn_i;
    logic                        cyc_i;
    logic                        stb_i;
    logic                        we_i;
    logic [`PERF_CSR_ADDR_W-1:0] adr_i;
    csr_word_t                   dat_i;
    priv_t                       priv_i;
    event_vec_t                  events_i;
    logic                        ack_o;
    logic                        err_o;
    csr_word_t                   dat_o;
    logic                        irq_o;

    // ------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------
    counter_t    m_cnt [NCNT];
    event_sel_t  m_sel [NCNT];
    cnt_mask_t   m_inh;
    cnt_mask_t   m_ovf;
    cnt_mask_t   m_irq_en;
    logic        m_irq;
    logic        pend_we;           // legal write that lands on the next edge
    csr_target_e pend_t;
    cnt_idx_t    pend_c;
    csr_word_t   pend_d;

    logic [31:0] seed;
    int          cycles;
    logic        ev_hold;           // drive ev_fixed instead of random flags
    event_vec_t  ev_fixed;
    event_vec_t  ev_driven;         // flags the DUT counts at the next edge

    top_perfmon dut_i (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .cyc_i    (cyc_i),
        .stb_i    (stb_i),
        .we_i     (we_i),
        .adr_i    (adr_i),
        .dat_i    (dat_i),
        .ack_o    (ack_o),
        .err_o    (err_o),
        .dat_o    (dat_o),
        .priv_i   (priv_i),
        .events_i (events_i),
        .irq_o    (irq_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [31:0] rand32();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {seed[15:0], seed[31:16]};       // low lcg bits repeat quickly
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_rdata(input csr_word_t got, input csr_word_t exp);
        if (got !== exp) begin
            stop_run($sformatf("FAILED dat_o: got 0x%08h expected 0x%08h", got, exp));
        end
    endtask

    task automatic check_resp_kind(input logic ack, input logic err,
                                   input logic exp_ack, input logic exp_err);
        if (ack !== exp_ack || err !== exp_err) begin
            stop_run($sformatf("FAILED ack_o/err_o: got 0x%h/0x%h expected 0x%h/0x%h",
                               ack, err, exp_ack, exp_err));
        end
    endtask

    task automatic check_irq(input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("FAILED irq_o: got 0x%h expected 0x%h", got, exp));
        end
    endtask

    // csr number -> class, counter and legality, straight from the csr map
    function automatic void model_decode(input logic [`PERF_CSR_ADDR_W-1:0] a,
                                         input logic w, input priv_t p,
                                         output csr_target_e t, output cnt_idx_t c,
                                         output logic bad);
        t = TGT_NONE;
        c = '0;
        for (int k = 0; k < NCNT; k++) begin
            if (a == `PERF_CSR_EVENT_BASE + 12'(k)) begin
                t = TGT_EVENT;
                c = cnt_idx_t'(k);
            end
            if (a == `PERF_CSR_CNT_LO_BASE + 12'(k) || a == `PERF_CSR_RO_LO_BASE + 12'(k)) begin
                t = TGT_CNT_LO;
                c = cnt_idx_t'(k);
            end
            if (a == `PERF_CSR_CNT_HI_BASE + 12'(k) || a == `PERF_CSR_RO_HI_BASE + 12'(k)) begin
                t = TGT_CNT_HI;
                c = cnt_idx_t'(k);
            end
        end
        if (a == `PERF_CSR_INHIBIT) t = TGT_INHIBIT;
        if (a == `PERF_CSR_OVF) t = TGT_OVF;
        if (a == `PERF_CSR_IRQ_EN) t = TGT_IRQ_EN;
        bad = (t == TGT_NONE) || (w && a[11:10] == 2'b11) || (a[9:8] > p);
    endfunction

    function automatic csr_word_t model_read(input csr_target_e t, input cnt_idx_t c);
        case (t)
            TGT_INHIBIT: return csr_word_t'(m_inh) << `PERF_HPM_FIRST;
            TGT_EVENT:   return csr_word_t'(m_sel[c]);
            TGT_CNT_LO:  return m_cnt[c][31:0];
            TGT_CNT_HI:  return m_cnt[c][63:32];
            TGT_OVF:     return csr_word_t'(m_ovf);
            TGT_IRQ_EN:  return csr_word_t'(m_irq_en);
            default:     return '0;
        endcase
    endfunction

    // one clock edge of the model, all decisions on the state before the edge
    function automatic void model_update();
        cnt_mask_t wrap;
        logic      irq_next;
        logic      hit;
        logic      en;
        int        s;
        wrap     = '0;
        irq_next = |(m_ovf & m_irq_en);
        for (int i = 0; i < NCNT; i++) begin
            s   = int'(m_sel[i]);
            en  = 1'b0;
            if (s >= 1 && s <= `PERF_NUM_EVENTS) en = ev_driven[3'(s - 1)] && !m_inh[i];
            hit = pend_we && pend_c == cnt_idx_t'(i);
            if (hit && pend_t == TGT_CNT_LO) begin
                m_cnt[i][31:0] = pend_d;                // write beats the increment
            end else if (hit && pend_t == TGT_CNT_HI) begin
                m_cnt[i][63:32] = pend_d;
            end else if (en) begin
                wrap[i]  = (m_cnt[i] == '1);
                m_cnt[i] = m_cnt[i] + 64'd1;
            end
            if (hit && pend_t == TGT_EVENT) m_sel[i] = pend_d[3:0];
        end
        if (pend_we && pend_t == TGT_INHIBIT) m_inh = pend_d[`PERF_HPM_FIRST +: NCNT];
        if (pend_we && pend_t == TGT_IRQ_EN) m_irq_en = pend_d[NCNT-1:0];
        if (pend_we && pend_t == TGT_OVF) m_ovf = m_ovf & ~pend_d[NCNT-1:0];
        m_ovf   = m_ovf | wrap;
        m_irq   = irq_next;
        pend_we = 1'b0;
    endfunction

    // ------------------------------------------------------------------
    // clocking of the stimulus
    // ------------------------------------------------------------------
    task automatic step();
        @(posedge clk_i);
        model_update();
        cycles++;
        if (cycles > CYCLE_LIMIT) stop_run($sformatf("timeout, run took over %0d cycles",
                                                     CYCLE_LIMIT));
        ev_driven = ev_hold ? ev_fixed : event_vec_t'(rand32());
        events_i <= ev_driven;
    endtask

    // one wishbone classic transfer, entered and left just after a rising edge
    task automatic do_xfer(input logic w, input logic [`PERF_CSR_ADDR_W-1:0] a,
                           input csr_word_t d, input priv_t p,
                           output csr_word_t rd, output logic got_err);
        csr_target_e t;
        cnt_idx_t    c;
        logic        bad;
        csr_word_t   exp_rd;
        model_decode(a, w, p, t, c, bad);
        cyc_i  <= 1'b1;
        stb_i  <= 1'b1;
        we_i   <= w;
        adr_i  <= a;
        dat_i  <= d;
        priv_i <= p;
        step();                                         // decode stage samples stb
        exp_rd  = (bad || w) ? '0 : model_read(t, c);   // value held before the access edge
        pend_we = !bad && w;
        pend_t  = t;
        pend_c  = c;
        pend_d  = d;
        @(negedge clk_i);
        check_resp_kind(ack_o, err_o, 1'b0, 1'b0);      // too early for a response
        step();
        @(negedge clk_i);
        check_resp_kind(ack_o, err_o, !bad, bad);
        if (bad || !w) check_rdata(dat_o, exp_rd);      // err carries zero data
        check_irq(irq_o, m_irq);
        rd      = dat_o;
        got_err = err_o;
        step();
        cyc_i <= 1'b0;                                  // master saw the response
        stb_i <= 1'b0;
        @(negedge clk_i);
        check_resp_kind(ack_o, err_o, 1'b0, 1'b0);      // single cycle pulse
        step();                                         // stb seen low
    endtask

    task automatic write_read_back(input logic [`PERF_CSR_ADDR_W-1:0] a, input csr_word_t mask);
        csr_word_t wd;
        csr_word_t rd;
        logic      e;
        wd = rand32();
        do_xfer(1'b1, a, wd, 2'd3, rd, e);
        do_xfer(1'b0, a, '0, 2'd3, rd, e);
        check_rdata(rd, wd & mask);
    endtask

    task automatic read_counters(input priv_t p);
        csr_word_t rd;
        logic      e;
        ev_hold  = 1'b1;                                // quiet events, exact values
        ev_fixed = '0;
        for (int i = 0; i < NCNT; i++) begin
            do_xfer(1'b0, `PERF_CSR_CNT_LO_BASE + 12'(i), '0, 2'd3, rd, e);
            do_xfer(1'b0, `PERF_CSR_CNT_HI_BASE + 12'(i), '0, 2'd3, rd, e);
            do_xfer(1'b0, `PERF_CSR_RO_LO_BASE + 12'(i), '0, p, rd, e);
            do_xfer(1'b0, `PERF_CSR_RO_HI_BASE + 12'(i), '0, p, rd, e);
        end
    endtask

    function automatic logic [`PERF_CSR_ADDR_W-1:0] pick_addr(input logic [31:0] r);
        logic [`PERF_CSR_ADDR_W-1:0] k;
        k = 12'(r[1:0]);
        case (r[6:3])
            4'd0:       return `PERF_CSR_INHIBIT;
            4'd1, 4'd2: return `PERF_CSR_EVENT_BASE + k;
            4'd3, 4'd4: return `PERF_CSR_CNT_LO_BASE + k;
            4'd5, 4'd6: return `PERF_CSR_CNT_HI_BASE + k;
            4'd7:       return `PERF_CSR_RO_LO_BASE + k;
            4'd8:       return `PERF_CSR_RO_HI_BASE + k;
            4'd9:       return `PERF_CSR_OVF;
            4'd10:      return `PERF_CSR_IRQ_EN;
            4'd11:      return `PERF_CSR_CNT_LO_BASE + 12'd4 + k;   // past the last counter
            4'd12:      return `PERF_CSR_EVENT_BASE - 12'd1;        // unimplemented event csr
            4'd13:      return r[31:20];                            // anything at all
            default:    return `PERF_CSR_RO_LO_BASE + k;
        endcase
    endfunction

    // ------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------
    initial begin
        csr_word_t                   rd;
        logic                        got_err;
        logic [31:0]                 r;
        logic [`PERF_CSR_ADDR_W-1:0] a;
        rstn_i    = 1'b0;
        cyc_i     = 1'b0;
        stb_i     = 1'b0;
        we_i      = 1'b0;
        adr_i     = '0;
        dat_i     = '0;
        priv_i    = 2'd3;
        events_i  = '0;
        seed      = 32'd58;
        cycles    = 0;
        ev_hold   = 1'b0;
        ev_fixed  = '0;
        ev_driven = '0;
        pend_we   = 1'b0;
        for (int i = 0; i < NCNT; i++) begin
            m_cnt[i] = '0;
            m_sel[i] = '0;
        end
        m_inh    = '0;
        m_ovf    = '0;
        m_irq_en = '0;
        m_irq    = 1'b0;
        repeat (8) @(posedge clk_i);
        rstn_i <= 1'b1;

        // selectors keep 4 bits, inhibit bits 6:3, irq enable 4 bits
        for (int i = 0; i < NCNT; i++) write_read_back(`PERF_CSR_EVENT_BASE + 12'(i), 32'hF);
        write_read_back(`PERF_CSR_INHIBIT, 32'h78);
        write_read_back(`PERF_CSR_IRQ_EN, 32'hF);

        // counting against the model, distinct event per counter
        for (int i = 0; i < NCNT; i++) begin
            do_xfer(1'b1, `PERF_CSR_EVENT_BASE + 12'(i), 32'(2 * i + 1), 2'd3, rd, got_err);
        end
        do_xfer(1'b1, `PERF_CSR_INHIBIT, '0, 2'd3, rd, got_err);
        ev_hold = 1'b0;
        repeat (40) step();
        read_counters(2'd3);
        for (int n = 0; n < 150; n++) begin
            r       = rand32();
            a       = pick_addr(r);
            ev_hold = !r[10] && a[11];                  // counter read, events to zero
            ev_fixed = '0;
            do_xfer(r[10], a, rand32(), (r[9:8] == 2'b00) ? 2'd0 : 2'd3, rd, got_err);
            ev_hold = 1'b0;
            repeat (int'(r[12:11])) step();
        end
        read_counters(2'd0);

        // error rule: ro write, unknown number, user write of a machine csr
        do_xfer(1'b1, `PERF_CSR_RO_LO_BASE, rand32(), 2'd3, rd, got_err);
        check_resp_kind(!got_err, got_err, 1'b0, 1'b1);
        do_xfer(1'b1, 12'h5A5, rand32(), 2'd3, rd, got_err);
        check_resp_kind(!got_err, got_err, 1'b0, 1'b1);
        do_xfer(1'b1, `PERF_CSR_INHIBIT, rand32(), 2'd0, rd, got_err);
        check_resp_kind(!got_err, got_err, 1'b0, 1'b1);
        do_xfer(1'b0, `PERF_CSR_RO_HI_BASE + 12'd2, '0, 2'd0, rd, got_err);
        check_resp_kind(!got_err, got_err, 1'b1, 1'b0);   // user may read the shadow
        do_xfer(1'b0, `PERF_CSR_INHIBIT, '0, 2'd3, rd, got_err);
        read_counters(2'd0);

        // ---- overflow of counter 0, sticky bit and irq ----
        do_xfer(1'b1, `PERF_CSR_OVF, 32'hF, 2'd3, rd, got_err);
        do_xfer(1'b1, `PERF_CSR_INHIBIT, '0, 2'd3, rd, got_err);
        do_xfer(1'b1, `PERF_CSR_EVENT_BASE, 32'd1, 2'd3, rd, got_err);
        do_xfer(1'b1, `PERF_CSR_IRQ_EN, 32'd1, 2'd3, rd, got_err);
        do_xfer(1'b1, `PERF_CSR_CNT_HI_BASE, '1, 2'd3, rd, got_err);
        do_xfer(1'b1, `PERF_CSR_CNT_LO_BASE, '1, 2'd3, rd, got_err);
        ev_fixed = 8'h01;
        step();                                         // event 0 for one cycle
        ev_fixed = '0;
        step();                                         // 64 bit wrap
        do_xfer(1'b0, `PERF_CSR_OVF, '0, 2'd3, rd, got_err);
        check_rdata(rd & 32'h1, 32'h1);
        @(negedge clk_i);
        check_irq(irq_o, 1'b1);
        step();
        do_xfer(1'b1, `PERF_CSR_IRQ_EN, '0, 2'd3, rd, got_err);
        do_xfer(1'b0, `PERF_CSR_CNT_LO_BASE, '0, 2'd3, rd, got_err);
        @(negedge clk_i);
        check_irq(irq_o, 1'b0);                         // masked by irq enable
        step();
        do_xfer(1'b1, `PERF_CSR_IRQ_EN, 32'd1, 2'd3, rd, got_err);
        do_xfer(1'b1, `PERF_CSR_OVF, 32'h1, 2'd3, rd, got_err);   // write one to clear
        do_xfer(1'b0, `PERF_CSR_OVF, '0, 2'd3, rd, got_err);
        check_rdata(rd & 32'h1, 32'h0);
        @(negedge clk_i);
        check_irq(irq_o, 1'b0);
        step();

        $display("Simulation passed");
        $finish;
    end

endmodule

// File: verilog/csr_access_stage.sv
module csr_access_stage (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  csr_pkg::csr_req_t  req_i,
    input  csr_pkg::csr_word_t rd_data_i,
    output pmu_pkg::cnt_port_t cnt_port_o,
    output csr_pkg::wb_resp_t  resp_o
);
    import csr_pkg::*;
    import pmu_pkg::*;

    logic     legal;            // valid and allowed
    logic     fault;            // valid but illegal
    wb_resp_t resp_d;
    wb_resp_t resp_q;

    assign legal = req_i.valid && !req_i.illegal;
    assign fault = req_i.valid && req_i.illegal;

    // ----------------------------------------------------------------------
    // counter block port
    // ----------------------------------------------------------------------
    // target and counter go out on every cycle so the read mux sees them,
    // only the write strobe is qualified
    always_comb begin
        cnt_port_o.we     = legal && req_i.write;
        cnt_port_o.target = req_i.target;
        cnt_port_o.cnt    = req_i.cnt;
        cnt_port_o.wdata  = req_i.wdata;
    end

    // ----------------------------------------------------------------------
    // response
    // ----------------------------------------------------------------------
    always_comb begin
        resp_d.ack   = legal;
        resp_d.err   = fault;
        resp_d.rdata = '0;
        if (legal && !req_i.write) begin
            resp_d.rdata = rd_data_i;   // value before this edge
        end
    end

    // ack/err pulse one edge after req valid, rdata cleared with it
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            resp_q <= '0;
        end else begin
            resp_q <= resp_d;
        end
    end

    assign resp_o = resp_q;

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(resp_q.ack && resp_q.err));

endmodule

// File: verilog/csr_decode_stage.sv
`include "perf_consts.svh"

module csr_decode_stage (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               cyc_i,
    input  logic               stb_i,
    input  logic               we_i,
    input  csr_pkg::csr_addr_u adr_i,
    input  csr_pkg::csr_word_t dat_i,
    input  csr_pkg::priv_t     priv_i,
    output csr_pkg::csr_req_t  req_o
);
    import csr_pkg::*;

    logic        capture;       // first cycle of a new transfer
    logic        captured_q;    // transfer already taken, wait for stb low
    logic        valid_q;
    csr_req_t    req_d;
    csr_req_t    payload_q;
    csr_target_e tgt;

    // true when raw lies in [base, base + number of counters)
    function automatic logic in_block(logic [`PERF_CSR_ADDR_W-1:0] raw,
                                      logic [`PERF_CSR_ADDR_W-1:0] base);
        logic [`PERF_CSR_ADDR_W-1:0] off;
        off = raw - base;       // wraps high when raw < base
        return off < `PERF_CSR_ADDR_W'(`PERF_NUM_COUNTERS);
    endfunction

    assign capture = cyc_i && stb_i && !captured_q;

    // ----------------------------------------------------------------------
    // csr number -> register class
    // ----------------------------------------------------------------------
    always_comb begin
        tgt = TGT_NONE;
        if (adr_i.raw == `PERF_CSR_INHIBIT) begin
            tgt = TGT_INHIBIT;
        end else if (in_block(adr_i.raw, `PERF_CSR_EVENT_BASE)) begin
            tgt = TGT_EVENT;
        end else if (in_block(adr_i.raw, `PERF_CSR_CNT_LO_BASE) ||
                     in_block(adr_i.raw, `PERF_CSR_RO_LO_BASE)) begin
            tgt = TGT_CNT_LO;   // shadow maps onto the same half
        end else if (in_block(adr_i.raw, `PERF_CSR_CNT_HI_BASE) ||
                     in_block(adr_i.raw, `PERF_CSR_RO_HI_BASE)) begin
            tgt = TGT_CNT_HI;
        end else if (adr_i.raw == `PERF_CSR_OVF) begin
            tgt = TGT_OVF;
        end else if (adr_i.raw == `PERF_CSR_IRQ_EN) begin
            tgt = TGT_IRQ_EN;
        end
    end

    always_comb begin
        req_d.valid   = 1'b1;
        req_d.write   = we_i;
        req_d.addr    = adr_i;
        req_d.target  = tgt;
        // every block base ends in ...3, so the low index bits give the counter
        req_d.cnt     = adr_i.f.index[$bits(cnt_idx_t)-1:0] - cnt_idx_t'(`PERF_HPM_FIRST);
        req_d.wdata   = dat_i;
        req_d.illegal = (tgt == TGT_NONE) ||
                        (we_i && adr_i.f.access == CSR_ACCESS_RO) ||  // write to ro
                        (adr_i.f.priv > priv_i);                      // not enough priv
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q    <= 1'b0;
            captured_q <= 1'b0;
        end else begin
            valid_q <= capture;                     // single cycle pulse
            if (capture) begin
                captured_q <= 1'b1;
            end else if (!(cyc_i && stb_i)) begin
                captured_q <= 1'b0;                 // master ended the transfer
            end
        end
    end

    // request payload, held until the next capture
    always_ff @(posedge clk_i) begin
        if (capture) begin
            payload_q <= req_d;
        end
    end

    always_comb begin
        req_o       = payload_q;
        req_o.valid = valid_q;
    end

    // one transfer at a time, and stb must be held through the ack
    a_single_valid: assert property (@(posedge clk_i) disable iff (!rstn_i)
        valid_q |=> !valid_q);

endmodule

// File: verilog/csr_pkg.sv
`include "perf_consts.svh"

package csr_pkg;

    // ----------------------------------------------------------------------
    // bus side words
    // ----------------------------------------------------------------------
    typedef logic [`PERF_XLEN-1:0] csr_word_t;          // one wishbone data word
    typedef logic [1:0] priv_t;                         // 0 user, 3 machine

    // counter number inside the hpm block
    typedef logic [$clog2(`PERF_NUM_COUNTERS)-1:0] cnt_idx_t;

    // access field value of a read-only csr
    localparam logic [1:0] CSR_ACCESS_RO = 2'b11;

    // riscv view of a csr number, msb first
    typedef struct packed {
        logic [1:0] access;                             // 11 = read only
        priv_t      priv;                               // lowest privilege allowed
        logic [7:0] index;
    } csr_fields_t;

    // same 12 bits, used as a lookup key or as riscv fields
    typedef union packed {
        logic [`PERF_CSR_ADDR_W-1:0] raw;
        csr_fields_t                 f;
    } csr_addr_u;

    // register class after decode
    typedef enum logic [2:0] {
        TGT_NONE,
        TGT_INHIBIT,
        TGT_EVENT,
        TGT_CNT_LO,
        TGT_CNT_HI,
        TGT_OVF,
        TGT_IRQ_EN
    } csr_target_e;

    // decode -> access stage
    typedef struct packed {
        logic        valid;                             // one cycle per transfer
        logic        write;
        csr_addr_u   addr;
        csr_target_e target;
        cnt_idx_t    cnt;                               // only for per-counter targets
        csr_word_t   wdata;
        logic        illegal;                           // answer with err, no write
    } csr_req_t;

    // access stage -> wishbone
    typedef struct packed {
        logic      ack;
        logic      err;
        csr_word_t rdata;
    } wb_resp_t;

endpackage

// File: verilog/hpm_counters.sv
`include "perf_consts.svh"

module hpm_counters (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  pmu_pkg::cnt_port_t  port_i,
    input  pmu_pkg::event_vec_t events_i,
    output csr_pkg::csr_word_t  rd_data_o,
    output logic                irq_o
);
    import csr_pkg::*;
    import pmu_pkg::*;

    localparam int NCNT = `PERF_NUM_COUNTERS;

    counter_t   cnt_q [NCNT];
    event_sel_t sel_q [NCNT];
    cnt_mask_t  inhibit_q;      // mcountinhibit[6:3]
    cnt_mask_t  ovf_q;          // sticky
    cnt_mask_t  irq_en_q;
    logic       irq_q;

    logic [(1 << `PERF_SEL_W)-1:0] ev_ext;    // indexed directly by selector
    cnt_mask_t  cnt_en;         // counter increments this edge
    cnt_mask_t  wr_lo;
    cnt_mask_t  wr_hi;
    cnt_mask_t  wr_sel;
    cnt_mask_t  wrap;           // all ones and counting
    cnt_mask_t  ovf_clr;        // w1c mask
    logic       wr_inhibit;
    logic       wr_ovf;
    logic       wr_irq_en;

    // ----------------------------------------------------------------------
    // event select and write decode
    // ----------------------------------------------------------------------
    always_comb begin
        logic port_hit;
        ev_ext = '0;
        ev_ext[`PERF_NUM_EVENTS:1] = events_i;     // bit 0 = "count nothing"
        for (int i = 0; i < NCNT; i++) begin
            port_hit  = port_i.we && (port_i.cnt == cnt_idx_t'(i));
            wr_lo[i]  = port_hit && (port_i.target == TGT_CNT_LO);
            wr_hi[i]  = port_hit && (port_i.target == TGT_CNT_HI);
            wr_sel[i] = port_hit && (port_i.target == TGT_EVENT);
            cnt_en[i] = ev_ext[sel_q[i]] && !inhibit_q[i];
            // a write replaces the increment, so no wrap then
            wrap[i]   = cnt_en[i] && (&cnt_q[i]) && !wr_lo[i] && !wr_hi[i];
        end
        wr_inhibit = port_i.we && (port_i.target == TGT_INHIBIT);
        wr_ovf     = port_i.we && (port_i.target == TGT_OVF);
        wr_irq_en  = port_i.we && (port_i.target == TGT_IRQ_EN);
        ovf_clr    = wr_ovf ? port_i.wdata[NCNT-1:0] : cnt_mask_t'(0);
    end

    // ----------------------------------------------------------------------
    // registers
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < NCNT; i++) begin
                cnt_q[i] <= '0;
                sel_q[i] <= '0;
            end
            inhibit_q <= '0;
            ovf_q     <= '0;
            irq_en_q  <= '0;
            irq_q     <= 1'b0;
        end else begin
            for (int i = 0; i < NCNT; i++) begin
                if (wr_lo[i]) begin
                    cnt_q[i][`PERF_XLEN-1:0] <= port_i.wdata;
                end else if (wr_hi[i]) begin
                    cnt_q[i][`PERF_CNT_W-1:`PERF_XLEN] <= port_i.wdata;
                end else if (cnt_en[i]) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;     // low word carries into high
                end
                if (wr_sel[i]) begin
                    sel_q[i] <= port_i.wdata[`PERF_SEL_W-1:0];
                end
            end
            if (wr_inhibit) begin
                inhibit_q <= port_i.wdata[`PERF_HPM_FIRST +: NCNT];
            end
            if (wr_irq_en) begin
                irq_en_q <= port_i.wdata[NCNT-1:0];
            end
            ovf_q <= (ovf_q & ~ovf_clr) | wrap;      // a new wrap beats the clear
            irq_q <= |(ovf_q & irq_en_q);
        end
    end

    assign irq_o = irq_q;

    // ----------------------------------------------------------------------
    // read mux, combinational on the access stage request
    // ----------------------------------------------------------------------
    always_comb begin
        rd_data_o = '0;
        case (port_i.target)
            TGT_INHIBIT: rd_data_o[`PERF_HPM_FIRST +: NCNT] = inhibit_q;
            TGT_EVENT:   rd_data_o[`PERF_SEL_W-1:0] = sel_q[port_i.cnt];
            TGT_CNT_LO:  rd_data_o = cnt_q[port_i.cnt][`PERF_XLEN-1:0];
            TGT_CNT_HI:  rd_data_o = cnt_q[port_i.cnt][`PERF_CNT_W-1:`PERF_XLEN];
            TGT_OVF:     rd_data_o[NCNT-1:0] = ovf_q;
            TGT_IRQ_EN:  rd_data_o[NCNT-1:0] = irq_en_q;
            default:     rd_data_o = '0;
        endcase
    end

    // ovf only rises out of a real 64 bit wrap
    for (genvar g = 0; g < NCNT; g++) begin : g_ovf_chk
        a_ovf_rise: assert property (@(posedge clk_i) disable iff (!rstn_i)
            $rose(ovf_q[g]) |-> $past(cnt_en[g] && (&cnt_q[g])));
    end

endmodule

// File: verilog/perf_consts.svh
`ifndef PERF_CONSTS_SVH
`define PERF_CONSTS_SVH

// ----------------------------------------------------------------------
// sizes of the counter block
// ----------------------------------------------------------------------
`define PERF_NUM_COUNTERS       4       // mhpmcounter3 .. mhpmcounter6
`define PERF_NUM_EVENTS         8       // pipeline event flags
`define PERF_XLEN               32      // wishbone data width
`define PERF_CNT_W              64      // full counter width
`define PERF_SEL_W              4       // implemented bits of mhpmevent
`define PERF_CSR_ADDR_W         12      // csr number = word address
`define PERF_HPM_FIRST          3       // first hpm index, bit 3 of mcountinhibit

// ----------------------------------------------------------------------
// csr numbers
// ----------------------------------------------------------------------
`define PERF_CSR_INHIBIT        12'h320 // mcountinhibit
`define PERF_CSR_EVENT_BASE     12'h323 // mhpmevent3
`define PERF_CSR_CNT_LO_BASE    12'hB03 // mhpmcounter3
`define PERF_CSR_CNT_HI_BASE    12'hB83 // mhpmcounter3h
`define PERF_CSR_RO_LO_BASE     12'hC03 // hpmcounter3, user shadow
`define PERF_CSR_RO_HI_BASE     12'hC83 // hpmcounter3h, user shadow
`define PERF_CSR_OVF            12'h7C0 // custom sticky overflow, w1c
`define PERF_CSR_IRQ_EN         12'h7C1 // custom overflow irq enable

`endif

// File: verilog/pmu_pkg.sv
`include "perf_consts.svh"

package pmu_pkg;

    import csr_pkg::*;

    // ----------------------------------------------------------------------
    // event and counter types
    // ----------------------------------------------------------------------
    typedef logic [`PERF_NUM_EVENTS-1:0] event_vec_t;   // one flag per event input

    // 0 counts nothing, n selects event n-1
    typedef logic [`PERF_SEL_W-1:0] event_sel_t;

    typedef logic [`PERF_CNT_W-1:0] counter_t;

    // one bit per counter: inhibit, ovf, irq enable
    typedef logic [`PERF_NUM_COUNTERS-1:0] cnt_mask_t;

    // access stage -> counter block, combinational
    typedef struct packed {
        logic        we;                                // legal write strobe
        csr_target_e target;                            // also steers the read mux
        cnt_idx_t    cnt;
        csr_word_t   wdata;
    } cnt_port_t;

endpackage

// File: verilog/top_perfmon.sv
`include "perf_consts.svh"

module top_perfmon (
    input  logic                        clk_i,
    input  logic                        rstn_i,

    // ----------------------------------------------------------------------
    // wishbone classic slave, word address = csr number
    // ----------------------------------------------------------------------
    input  logic                        cyc_i,
    input  logic                        stb_i,
    input  logic                        we_i,
    input  logic [`PERF_CSR_ADDR_W-1:0] adr_i,
    input  csr_pkg::csr_word_t          dat_i,
    output logic                        ack_o,
    output logic                        err_o,
    output csr_pkg::csr_word_t          dat_o,

    // ----------------------------------------------------------------------
    // core side
    // ----------------------------------------------------------------------
    input  csr_pkg::priv_t              priv_i,     // user or machine
    input  pmu_pkg::event_vec_t         events_i,   // pipeline event flags
    output logic                        irq_o       // counter overflow interrupt
);
    import csr_pkg::*;
    import pmu_pkg::*;

    csr_req_t  req;             // decode -> access, registered
    cnt_port_t cnt_port;        // access -> counters
    csr_word_t rd_data;         // counters -> access
    wb_resp_t  resp;

    csr_decode_stage decode_i (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .cyc_i  (cyc_i),
        .stb_i  (stb_i),
        .we_i   (we_i),
        .adr_i  (adr_i),
        .dat_i  (dat_i),
        .priv_i (priv_i),
        .req_o  (req)
    );

    csr_access_stage access_i (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .req_i      (req),
        .rd_data_i  (rd_data),
        .cnt_port_o (cnt_port),
        .resp_o     (resp)
    );

    hpm_counters counters_i (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .port_i    (cnt_port),
        .events_i  (events_i),
        .rd_data_o (rd_data),
        .irq_o     (irq_o)
    );

    assign ack_o = resp.ack;
    assign err_o = resp.err;
    assign dat_o = resp.rdata;

endmodule
